/* Makefile */
VERILATOR ?= verilator
TOP ?= ddrCtrlTb
FILELIST ?= ddrCtrl.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
FAIL_TEXT ?= Test failed

SRCS := $(shell cat $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ddrCtrl.f */
hw/ddrPkg.sv
hw/apbDecode.sv
hw/ddrSequencer.sv
hw/readCapture.sv
hw/ddrCtrlTop.sv
testbench/sdramModel.sv
testbench/ddrCtrl_sva.sv
testbench/ddrCtrlTb.sv

/* hw/apbDecode.sv */
`default_nettype none

module apbDecode (
	input logic clk133_270,
	input logic starting,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic initDone,
	input ddrPkg::readResult_t result,
	output logic reqValid,
	output ddrPkg::ddrRequest_t reqData
);
	import ddrPkg::*;

	apbAddr_t addrSel;
	logic isCmdWrite;
	logic quickDone;
	logic cmdAccept;
	logic legal;
	logic [31:0] readData;
	logic [31:0] wdataReg;
	logic [31:0] rdataReg;

	assign addrSel = apbAddr_t'(paddr);
	assign isCmdWrite = (addrSel == CMD) && pwrite;
	// everything except a CMD write finishes right after setup
	assign quickDone = psel && !penable && !isCmdWrite;
	assign cmdAccept = psel && penable && !pready && isCmdWrite && !busy;

	always_comb begin
		legal = 1'b0;
		readData = '0;
		case (addrSel)
			CMD: legal = pwrite;
			WDATA: legal = pwrite;
			RDATA: begin
				legal = !pwrite;
				readData = rdataReg;
			end
			STATUS: begin
				legal = !pwrite;
				readData = {30'd0, busy, initDone};
			end
			default: legal = 1'b0;
		endcase
	end

	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			pready <= 1'b0;
			pslverr <= 1'b0;
			reqValid <= 1'b0;
		end else begin
			pready <= 1'b0;
			pslverr <= 1'b0;
			reqValid <= 1'b0;
			if (quickDone) begin
				pready <= 1'b1;
				pslverr <= !legal;
			end else if (cmdAccept) begin
				pready <= 1'b1;
				reqValid <= 1'b1; // single cycle pulse
			end
		end
	end

	always_ff @(posedge clk133_270) begin
		if (quickDone && legal && addrSel == WDATA)
			wdataReg <= pwdata;
		if (quickDone)
			prdata <= readData;
		if (result.valid)
			rdataReg <= result.data;
		if (cmdAccept)
			reqData <= '{op: accessOp_t'(pwdata[31]), bank: pwdata[30:29],
				row: pwdata[28:16], col: pwdata[9:0], wdata: wdataReg};
	end

endmodule

`default_nettype wire

/* hw/ddrCtrlTop.sv */
`default_nettype none

module ddrCtrlTop #(
	parameter int unsigned powerUpCycles = ddrPkg::powerUpDefault
) (
	input logic clk133_270,
	input logic starting,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output ddrPkg::ddrPins_t pins,
	output logic [15:0] dqOut,
	output logic dqOe,
	input logic [15:0] dqIn
);
	import ddrPkg::*;

	logic reqValid;
	ddrRequest_t reqData;
	logic busy;
	logic initDone;
	logic readIssue;
	readResult_t result;

	apbDecode apbDecode_i (
		.clk133_270(clk133_270),
		.starting(starting),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.initDone(initDone),
		.result(result),
		.reqValid(reqValid),
		.reqData(reqData)
	);

	ddrSequencer #(
		.powerUpCycles(powerUpCycles)
	) ddrSequencer_i (
		.clk133_270(clk133_270),
		.starting(starting),
		.reqValid(reqValid),
		.reqData(reqData),
		.busy(busy),
		.initDone(initDone),
		.pins(pins),
		.dqOut(dqOut),
		.dqOe(dqOe),
		.readIssue(readIssue)
	);

	readCapture readCapture_i (
		.clk133_270(clk133_270),
		.starting(starting),
		.readIssue(readIssue),
		.dqIn(dqIn),
		.result(result)
	);

endmodule

`default_nettype wire

/* hw/ddrPkg.sv */
`default_nettype none

package ddrPkg;

	// noop gaps after each command, in cycles
	localparam int tRP = 3;
	localparam int tMRD = 2;
	localparam int tRFC = 11;
	localparam int tRCD = 3;
	localparam int writeLength = 3;
	localparam int readLength = 4;

	localparam int casLatency = 2;
	localparam int powerUpDefault = 26600;

	localparam logic [12:0] extModeWord = 13'b0000000000000; // DLL enabled, full drive
	localparam logic [12:0] modeWordDllReset = 13'b0000_1_0_010_0_001;
	localparam logic [12:0] modeWord = 13'b0000_0_0_010_0_001; // CL2, BL2 sequential
	localparam logic [12:0] prechargeAll = 13'h0400; // A10 high

	typedef enum logic [3:0] {
		CMD = 4'h0,
		WDATA = 4'h4,
		RDATA = 4'h8,
		STATUS = 4'hC
	} apbAddr_t;

	// RAS, CAS, WE
	typedef enum logic [2:0] {
		cmdLoadMode = 3'b000,
		cmdRefresh = 3'b001,
		cmdPrecharge = 3'b010,
		cmdActivate = 3'b011,
		cmdWrite = 3'b100,
		cmdRead = 3'b101,
		cmdNoop = 3'b111
	} ddrCommand_t;

	typedef enum logic {
		opWrite = 1'b0,
		opRead = 1'b1
	} accessOp_t;

	typedef enum logic [3:0] {
		initWait,
		initPrecharge0,
		initLoadExtMode,
		initLoadMode0,
		initPrecharge1,
		initRefresh0,
		initRefresh1,
		initLoadMode1,
		mainIdle,
		mainActivate,
		mainAccess,
		mainPrecharge
	} seqState_t;

	typedef struct packed {
		accessOp_t op;
		logic [1:0] bank;
		logic [12:0] row;
		logic [9:0] col;
		logic [31:0] wdata;
	} ddrRequest_t;

	typedef struct packed {
		logic cke;
		logic cs;
		ddrCommand_t cmd;
		logic [1:0] ba;
		logic [12:0] addr;
	} ddrPins_t;

	typedef struct packed {
		logic valid;
		logic [31:0] data;
	} readResult_t;

endpackage

`default_nettype wire

/* hw/ddrSequencer.sv */
`default_nettype none

module ddrSequencer #(
	parameter int unsigned powerUpCycles = ddrPkg::powerUpDefault
) (
	input logic clk133_270,
	input logic starting,
	input logic reqValid,
	input ddrPkg::ddrRequest_t reqData,
	output logic busy,
	output logic initDone,
	output ddrPkg::ddrPins_t pins,
	output logic [15:0] dqOut,
	output logic dqOe,
	output logic readIssue
);
	import ddrPkg::*;

	seqState_t state;
	int unsigned powerUpCnt;
	logic [3:0] gap;
	ddrRequest_t req;
	logic writeBeat;

	assign busy = (state != mainIdle) || reqValid;

	// beats go out in the two cycles after the write command
	assign writeBeat = (state == mainAccess) && (req.op == opWrite)
		&& (gap == 4'(writeLength) || gap == 4'(writeLength - 1));

	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			state <= initWait;
			powerUpCnt <= powerUpCycles;
			gap <= '0;
			initDone <= 1'b0;
			dqOe <= 1'b0;
			readIssue <= 1'b0;
			pins <= '{cke: 1'b0, cs: 1'b1, cmd: cmdNoop, ba: 2'b00, addr: 13'd0};
		end else begin
			pins.cmd <= cmdNoop;
			readIssue <= 1'b0;
			dqOe <= writeBeat;
			if (gap != '0) begin
				gap <= gap - 4'd1;
			end else begin
				case (state)
					initWait: begin
						if (powerUpCnt != 0) begin
							powerUpCnt <= powerUpCnt - 1;
						end else begin
							pins.cke <= 1'b1;
							pins.cs <= 1'b0;
							pins.cmd <= cmdPrecharge;
							pins.addr <= prechargeAll;
							gap <= 4'(tRP);
							state <= initPrecharge0;
						end
					end
					initPrecharge0: begin
						pins.cmd <= cmdLoadMode;
						pins.ba <= 2'b01; // extended mode register
						pins.addr <= extModeWord;
						gap <= 4'(tMRD);
						state <= initLoadExtMode;
					end
					initLoadExtMode: begin
						pins.cmd <= cmdLoadMode;
						pins.ba <= 2'b00;
						pins.addr <= modeWordDllReset;
						gap <= 4'(tMRD);
						state <= initLoadMode0;
					end
					initLoadMode0: begin
						pins.cmd <= cmdPrecharge;
						pins.addr <= prechargeAll;
						gap <= 4'(tRP);
						state <= initPrecharge1;
					end
					initPrecharge1: begin
						pins.cmd <= cmdRefresh;
						gap <= 4'(tRFC);
						state <= initRefresh0;
					end
					initRefresh0: begin
						pins.cmd <= cmdRefresh;
						gap <= 4'(tRFC);
						state <= initRefresh1;
					end
					initRefresh1: begin
						pins.cmd <= cmdLoadMode;
						pins.ba <= 2'b00;
						pins.addr <= modeWord; // drop DLL reset
						gap <= 4'(tMRD);
						state <= initLoadMode1;
					end
					initLoadMode1: begin
						initDone <= 1'b1;
						state <= mainIdle;
					end
					mainIdle: begin
						if (reqValid) begin
							pins.cmd <= cmdActivate;
							pins.ba <= reqData.bank;
							pins.addr <= reqData.row;
							gap <= 4'(tRCD);
							state <= mainActivate;
						end
					end
					mainActivate: begin
						pins.addr <= {3'b000, req.col}; // A10 low, no auto precharge
						if (req.op == opWrite) begin
							pins.cmd <= cmdWrite;
							gap <= 4'(writeLength);
						end else begin
							pins.cmd <= cmdRead;
							readIssue <= 1'b1;
							gap <= 4'(readLength);
						end
						state <= mainAccess;
					end
					mainAccess: begin
						pins.cmd <= cmdPrecharge;
						pins.addr <= prechargeAll;
						gap <= 4'(tRP);
						state <= mainPrecharge;
					end
					mainPrecharge: state <= mainIdle;
					default: state <= initWait;
				endcase
			end
		end
	end

	always_ff @(posedge clk133_270) begin
		if (state == mainIdle && reqValid)
			req <= reqData;
		// high word first
		dqOut <= (gap == 4'(writeLength)) ? req.wdata[31:16] : req.wdata[15:0];
	end

endmodule

`default_nettype wire

/* hw/readCapture.sv */
`default_nettype none

module readCapture (
	input logic clk133_270,
	input logic starting,
	input logic readIssue,
	input logic [15:0] dqIn,
	output ddrPkg::readResult_t result
);
	import ddrPkg::*;

	logic [casLatency:0] issueDelay; // bit n set n+1 cycles after readIssue
	logic validReg;
	logic [15:0] dataHi;
	logic [15:0] dataLo;

	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			issueDelay <= '0;
			validReg <= 1'b0;
		end else begin
			issueDelay <= {issueDelay[casLatency-1:0], readIssue};
			validReg <= issueDelay[casLatency];
		end
	end

	// first beat arrives casLatency cycles after the command
	always_ff @(posedge clk133_270) begin
		if (issueDelay[casLatency-1])
			dataHi <= dqIn;
		if (issueDelay[casLatency])
			dataLo <= dqIn;
	end

	assign result.valid = validReg;
	assign result.data = {dataHi, dataLo};

endmodule

`default_nettype wire

/* testbench/ddrCtrlTb.sv */
`default_nettype none

module ddrCtrlTb;
	timeunit 1ns;
	timeprecision 1ps;
	import ddrPkg::*;

	localparam int powerUp = 20;
	localparam int accessCount = 24; // CMD writes issued below plus one spare
	localparam int timeoutCycles = powerUp + 200 + 40 * accessCount;

	logic clk133_270;
	logic starting;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	ddrPins_t pins;
	logic [15:0] dqOut;
	logic dqOe;
	logic [15:0] dqIn;

	int mismatchCount = 0;
	int otherCount = 0;
	int cycleCount = 0;

	ddrCommand_t initSeq [7] = '{cmdPrecharge, cmdLoadMode, cmdLoadMode, cmdPrecharge,
		cmdRefresh, cmdRefresh, cmdLoadMode};

	ddrCtrlTop #(.powerUpCycles(powerUp)) ddrCtrlTop_i (.*);

	sdramModel sdramModel_i (.*);

	initial begin
		clk133_270 = 1'b0;
		forever #50 clk133_270 = ~clk133_270;
	end

	initial begin
		while (cycleCount < timeoutCycles) begin
			@(posedge clk133_270);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", timeoutCycles);
		$display("Test failed");
		$finish;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			mismatchCount++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		assert (cond) else begin
			otherCount++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	// runs one APB transfer and counts access cycles with pready low in waited
	task automatic apbTransfer(input logic write, input logic [3:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output int waited);
		waited = 0;
		@(negedge clk133_270);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk133_270);
		penable = 1'b1;
		while (!pready) begin
			@(negedge clk133_270);
			waited++;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk133_270);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic regWrite(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic err;
		int waited;
		apbTransfer(1'b1, addr, data, unused, err, waited);
		checkValue("pslverr", {31'd0, err}, 32'd0);
	endtask

	task automatic regRead(input logic [3:0] addr, output logic [31:0] data);
		logic err;
		int waited;
		apbTransfer(1'b0, addr, 32'd0, data, err, waited);
		checkValue("pslverr", {31'd0, err}, 32'd0);
	endtask

	task automatic waitIdle;
		logic [31:0] st;
		st = 32'h2;
		while (st[1])
			regRead(STATUS, st);
	endtask

	function automatic logic [31:0] cmdWord(input accessOp_t op, input logic [1:0] bank,
		input logic [12:0] row, input logic [9:0] col);
		return {op, bank, row, 6'd0, col};
	endfunction

	task automatic writeWord(input logic [1:0] bank, input logic [12:0] row,
		input logic [9:0] col, input logic [31:0] data);
		regWrite(WDATA, data);
		regWrite(CMD, cmdWord(opWrite, bank, row, col));
		waitIdle();
	endtask

	task automatic readWord(input logic [1:0] bank, input logic [12:0] row,
		input logic [9:0] col, output logic [31:0] data);
		regWrite(CMD, cmdWord(opRead, bank, row, col));
		waitIdle();
		regRead(RDATA, data);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] dA;
		logic [31:0] dB;
		logic [31:0] got;
		logic [31:0] st;
		logic err;
		int waited;
		int actBefore;
		int svaFails;

		void'($urandom(32'h0c065981));
		starting = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (4) @(negedge clk133_270);
		starting = 1'b0;

		// init sequence
		st = '0;
		while (!st[0])
			regRead(STATUS, st);
		checkValue("init command count", sdramModel_i.cmdCount, 32'd7);
		for (int i = 0; i < 7; i++)
			checkValue("init command", 32'(sdramModel_i.cmdLog[i[6:0]]), 32'(initSeq[i[2:0]]));
		regRead(STATUS, st);
		checkValue("STATUS", st, 32'h1);

		for (int n = 0; n < 8; n++) begin
			r = $urandom();
			d = $urandom();
			writeWord(r[1:0], r[14:2], r[24:15], d);
			readWord(r[1:0], r[14:2], r[24:15], got);
			checkValue("RDATA", got, d);
		end

		// same row and column in two banks
		r = $urandom();
		dA = $urandom();
		dB = $urandom();
		writeWord(2'd0, r[12:0], r[22:13], dA);
		writeWord(2'd2, r[12:0], r[22:13], dB);
		readWord(2'd0, r[12:0], r[22:13], got);
		checkValue("RDATA bank 0", got, dA);
		readWord(2'd2, r[12:0], r[22:13], got);
		checkValue("RDATA bank 2", got, dB);

		// back-pressure
		r = $urandom();
		d = $urandom();
		actBefore = sdramModel_i.activateCount;
		regWrite(WDATA, d);
		regWrite(CMD, cmdWord(opWrite, r[1:0], r[14:2], r[24:15]));
		regRead(STATUS, st);
		checkTrue(st[1], "STATUS busy bit clear during an access");
		apbTransfer(1'b1, CMD, cmdWord(opRead, r[1:0], r[14:2], r[24:15]), got, err, waited);
		checkTrue(waited > 1, "CMD write during an access was not stalled"); // idle CMD waits 1
		checkValue("last command at accept",
			32'(sdramModel_i.cmdLog[7'(sdramModel_i.cmdCount - 1)]), 32'(cmdPrecharge));
		checkValue("activates at accept", sdramModel_i.activateCount, actBefore + 1);
		waitIdle();
		checkValue("activates after access", sdramModel_i.activateCount, actBefore + 2);
		regRead(RDATA, got);
		checkValue("RDATA after stall", got, d);

		// illegal accesses
		apbTransfer(1'b0, WDATA, 32'd0, got, err, waited);
		checkValue("pslverr on WDATA read", {31'd0, err}, 32'd1);
		apbTransfer(1'b0, 4'h2, 32'd0, got, err, waited);
		checkValue("pslverr on unmapped read", {31'd0, err}, 32'd1);
		apbTransfer(1'b1, 4'h6, $urandom(), got, err, waited);
		checkValue("pslverr on unmapped write", {31'd0, err}, 32'd1);
		regRead(RDATA, got);
		checkValue("RDATA after errors", got, d);
		readWord(r[1:0], r[14:2], r[24:15], got);
		checkValue("RDATA reread", got, d);

		svaFails = ddrCtrlTop_i.ddrSequencer_i.ddrCtrl_sva_i.failCount;
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatchCount, otherCount, svaFails);
		if (mismatchCount + otherCount + svaFails == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/ddrCtrl_sva.sv */
`default_nettype none

module ddrCtrl_sva (
	input logic clk133_270,
	input logic starting,
	input ddrPkg::ddrPins_t pins,
	input logic dqOe,
	input ddrPkg::seqState_t state
);
	timeunit 1ns;
	timeprecision 1ps;
	import ddrPkg::*;

	int failCount = 0;
	int sinceCmd;
	int needGap;

	function automatic int gapFor(input ddrCommand_t c);
		case (c)
			cmdPrecharge: return tRP;
			cmdLoadMode: return tMRD;
			cmdRefresh: return tRFC;
			cmdActivate: return tRCD;
			cmdWrite: return writeLength;
			cmdRead: return readLength;
			default: return 0;
		endcase
	endfunction

	// noop cycles since the last command, and what that command requires
	always_ff @(posedge clk133_270 or posedge starting) begin
		if (starting) begin
			sinceCmd <= 0;
			needGap <= 0;
		end else if (pins.cmd != cmdNoop) begin
			sinceCmd <= 0;
			needGap <= gapFor(pins.cmd);
		end else if (sinceCmd < 255) begin
			sinceCmd <= sinceCmd + 1;
		end
	end

	gapRespected: assert property (@(posedge clk133_270) disable iff (starting)
		pins.cmd != cmdNoop |-> sinceCmd >= needGap)
		else begin
			failCount++;
			$error("command issued before the noop gap of the previous command ended");
		end

	writeBeatsFollow: assert property (@(posedge clk133_270) disable iff (starting)
		pins.cmd == cmdWrite |=> dqOe ##1 dqOe)
		else begin
			failCount++;
			$error("write command not followed by two cycles of dqOe");
		end

	dqOeOnlyAfterWrite: assert property (@(posedge clk133_270) disable iff (starting)
		dqOe |-> ($past(pins.cmd) == cmdWrite) || ($past(pins.cmd, 2) == cmdWrite))
		else begin
			failCount++;
			$error("dqOe high outside the two cycles after a write command");
		end

	powerUpQuiet: assert property (@(posedge clk133_270) disable iff (starting)
		state == initWait |-> pins.cs && !pins.cke)
		else begin
			failCount++;
			$error("chip select or clock enable active during the power-up wait");
		end

endmodule

bind ddrSequencer ddrCtrl_sva ddrCtrl_sva_i (
	.clk133_270(clk133_270),
	.starting(starting),
	.pins(pins),
	.dqOe(dqOe),
	.state(state)
);

`default_nettype wire

/* testbench/sdramModel.sv */
`default_nettype none

module sdramModel (
	input logic clk133_270,
	input ddrPkg::ddrPins_t pins,
	input logic [15:0] dqOut,
	input logic dqOe,
	output logic [15:0] dqIn
);
	timeunit 1ns;
	timeprecision 1ps;
	import ddrPkg::*;

	localparam int logDepth = 128;

	ddrCommand_t cmdLog [logDepth];
	int cmdCount = 0;
	int activateCount = 0;
	logic [15:0] mem [logic [24:0]]; // key is {bank, row, col}
	logic [12:0] openRow [4];
	logic [24:0] wrBase;
	logic wrBeat;
	logic [24:0] rdBase;
	int rdBeat = 0;

	// unwritten locations return a pattern of the full address
	function automatic logic [15:0] beatAt(input logic [24:0] key);
		if (mem.exists(key))
			return mem[key];
		return key[15:0] ^ {key[24:16], 7'h55};
	endfunction

	initial dqIn = '0;

	always @(posedge clk133_270) begin
		if (rdBeat == 1) begin
			dqIn <= beatAt(rdBase); // high word at the burst start
			rdBeat = 2;
		end else if (rdBeat == 2) begin
			dqIn <= beatAt({rdBase[24:1], ~rdBase[0]});
			rdBeat = 0;
		end
		if (dqOe) begin
			mem[{wrBase[24:1], wrBase[0] ^ wrBeat}] = dqOut;
			wrBeat = 1'b1;
		end
		if (!pins.cs && pins.cke && pins.cmd != cmdNoop) begin
			if (cmdCount < logDepth)
				cmdLog[cmdCount[6:0]] = pins.cmd;
			cmdCount++;
			case (pins.cmd)
				cmdActivate: begin
					openRow[pins.ba] = pins.addr;
					activateCount++;
				end
				cmdWrite: begin
					wrBase = {pins.ba, openRow[pins.ba], pins.addr[9:0]};
					wrBeat = 1'b0;
				end
				cmdRead: begin
					rdBase = {pins.ba, openRow[pins.ba], pins.addr[9:0]};
					rdBeat = 1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire
